/* hdl/arcade_ctrl_pkg.sv */
package arcade_ctrl_pkg;

	// PS/2 set 2 make codes
	localparam logic [7:0] key_up     = 8'h75;
	localparam logic [7:0] key_down   = 8'h72;
	localparam logic [7:0] key_left   = 8'h6B;
	localparam logic [7:0] key_right  = 8'h74;
	localparam logic [7:0] key_coin   = 8'h76; // esc
	localparam logic [7:0] key_start1 = 8'h05; // f1
	localparam logic [7:0] key_start2 = 8'h06; // f2
	localparam logic [7:0] key_fire   = 8'h29; // space
	localparam logic [7:0] key_bomb   = 8'h11; // alt

	// bit positions in the MiST joystick word
	localparam int joy_right = 0;
	localparam int joy_left  = 1;
	localparam int joy_down  = 2;
	localparam int joy_up    = 3;
	localparam int joy_fire  = 4;
	localparam int joy_bomb  = 5;

	// cabinet controls, all active high
	typedef struct packed {
		logic coin;
		logic start1;
		logic start2;
		logic up;
		logic down;
		logic left;
		logic right;
		logic fire;
		logic bomb;
	} cabinet_ctrl_t;

endpackage

/* hdl/arcade_io_top.sv */
module arcade_io_top
	import arcade_ctrl_pkg::*, arcade_video_pkg::*;
(
	input  logic          clk_mist,
	input  logic          arst_n,
	input  logic          key_strobe,
	input  logic          key_pressed,
	input  logic [7:0]    key_code,
	input  logic [7:0]    joystick_0,
	input  logic [7:0]    joystick_1,
	input  logic          rotate,
	input  logic          overlay_en,
	input  logic          cpu_strobe,
	input  vram_req_t     cpu_req,
	output cabinet_ctrl_t controls,
	output logic          cpu_done,
	output logic [7:0]    cpu_rdata,
	output rgb_t          pixel,
	output logic          de,
	output logic          hsync,
	output logic          vsync
);

	logic               vid_fetch;
	logic [vram_aw-1:0] vid_addr;
	logic [7:0]         vid_rdata;
	logic [7:0]         ram_rdata;
	vram_req_t          ram_req;

	control_mapper i_control_mapper (
		.clk_mist    (clk_mist),
		.arst_n      (arst_n),
		.key_strobe  (key_strobe),
		.key_pressed (key_pressed),
		.key_code    (key_code),
		.joystick_0  (joystick_0),
		.joystick_1  (joystick_1),
		.rotate      (rotate),
		.controls    (controls)
	);

	vram_arbiter i_vram_arbiter (
		.clk_mist   (clk_mist),
		.arst_n     (arst_n),
		.cpu_strobe (cpu_strobe),
		.cpu_req    (cpu_req),
		.vid_fetch  (vid_fetch),
		.vid_addr   (vid_addr),
		.ram_rdata  (ram_rdata),
		.cpu_done   (cpu_done),
		.cpu_rdata  (cpu_rdata),
		.vid_rdata  (vid_rdata),
		.ram_req    (ram_req)
	);

	video_ram i_video_ram (
		.clk_mist  (clk_mist),
		.ram_req   (ram_req),
		.ram_rdata (ram_rdata)
	);

	video_scanner i_video_scanner (
		.clk_mist   (clk_mist),
		.arst_n     (arst_n),
		.overlay_en (overlay_en),
		.vid_rdata  (vid_rdata),
		.vid_fetch  (vid_fetch),
		.vid_addr   (vid_addr),
		.pixel      (pixel),
		.de         (de),
		.hsync      (hsync),
		.vsync      (vsync)
	);

endmodule

/* hdl/arcade_video_pkg.sv */
package arcade_video_pkg;

	// horizontal timing in pixel clocks
	localparam int h_active     = 32;
	localparam int h_total      = 40;
	localparam int h_sync_start = 34;
	localparam int h_sync_end   = 37;

	// vertical timing in lines
	localparam int v_active    = 8;
	localparam int v_total     = 10;
	localparam int v_sync_line = 9;

	localparam int h_cnt_w = $clog2(h_total);
	localparam int v_cnt_w = $clog2(v_total);

	// bitmap memory, one bit per pixel
	localparam int bytes_per_line = h_active / 8;
	localparam int vram_depth     = 32;
	localparam int vram_aw        = 5;

	// one access to the video RAM
	typedef struct packed {
		logic               we;
		logic [vram_aw-1:0] addr;
		logic [7:0]         wdata;
	} vram_req_t;

	typedef struct packed {
		logic r;
		logic g;
		logic b;
	} rgb_t;

	// overlay bands, counted in visible rows
	localparam int band_top_rows    = 2;
	localparam int band_bottom_rows = 2;

	localparam rgb_t colour_top    = '{r: 1'b1, g: 1'b0, b: 1'b0};
	localparam rgb_t colour_mid    = '{r: 1'b1, g: 1'b1, b: 1'b1};
	localparam rgb_t colour_bottom = '{r: 1'b0, g: 1'b1, b: 1'b0};

endpackage

/* hdl/control_mapper.sv */
module control_mapper
	import arcade_ctrl_pkg::*;
(
	input  logic          clk_mist,
	input  logic          arst_n,
	input  logic          key_strobe,
	input  logic          key_pressed,
	input  logic [7:0]    key_code,
	input  logic [7:0]    joystick_0,
	input  logic [7:0]    joystick_1,
	input  logic          rotate,
	output cabinet_ctrl_t controls
);

	cabinet_ctrl_t btn; // keyboard button state
	logic [7:0]    joy;
	logic          src_up;
	logic          src_down;
	logic          src_left;
	logic          src_right;

	always_ff @(posedge clk_mist or negedge arst_n) begin
		if (!arst_n) begin
			btn <= '0;
		end else if (key_strobe) begin
			case (key_code)
				key_up:     btn.up     <= key_pressed;
				key_down:   btn.down   <= key_pressed;
				key_left:   btn.left   <= key_pressed;
				key_right:  btn.right  <= key_pressed;
				key_coin:   btn.coin   <= key_pressed;
				key_start1: btn.start1 <= key_pressed;
				key_start2: btn.start2 <= key_pressed;
				key_fire:   btn.fire   <= key_pressed;
				key_bomb:   btn.bomb   <= key_pressed;
				default:    ; // other keys ignored
			endcase
		end
	end

	// either player's stick drives the cabinet
	assign joy = joystick_0 | joystick_1;

	assign src_up    = btn.up    | joy[joy_up];
	assign src_down  = btn.down  | joy[joy_down];
	assign src_left  = btn.left  | joy[joy_left];
	assign src_right = btn.right | joy[joy_right];

	always_comb begin
		controls.coin   = btn.coin;
		controls.start1 = btn.start1;
		controls.start2 = btn.start2;
		controls.fire   = btn.fire | joy[joy_fire];
		controls.bomb   = btn.bomb | joy[joy_bomb];
		// rotated screen turns the stick a quarter turn
		if (rotate) begin
			controls.up    = src_right;
			controls.down  = src_left;
			controls.left  = src_up;
			controls.right = src_down;
		end else begin
			controls.up    = src_up;
			controls.down  = src_down;
			controls.left  = src_left;
			controls.right = src_right;
		end
	end

endmodule

/* hdl/video_ram.sv */
module video_ram
	import arcade_video_pkg::*;
(
	input  logic       clk_mist,
	input  vram_req_t  ram_req,
	output logic [7:0] ram_rdata
);

	logic [7:0] mem [vram_depth];

	always_ff @(posedge clk_mist) begin
		if (ram_req.we) begin
			mem[ram_req.addr] <= ram_req.wdata;
			ram_rdata         <= ram_req.wdata; // write-first
		end else begin
			ram_rdata <= mem[ram_req.addr];
		end
	end

endmodule

/* hdl/video_scanner.sv */
module video_scanner
	import arcade_video_pkg::*;
(
	input  logic               clk_mist,
	input  logic               arst_n,
	input  logic               overlay_en,
	input  logic [7:0]         vid_rdata,
	output logic               vid_fetch,
	output logic [vram_aw-1:0] vid_addr,
	output rgb_t               pixel,
	output logic               de,
	output logic               hsync,
	output logic               vsync
);

	logic [h_cnt_w-1:0] hcount;
	logic [v_cnt_w-1:0] vcount;
	logic [h_cnt_w-1:0] fetch_x; // pixel the next fetch is for
	logic [v_cnt_w-1:0] fetch_y;
	logic [7:0]         shifter;
	logic               visible;
	rgb_t               band_colour;

	always_ff @(posedge clk_mist or negedge arst_n) begin
		if (!arst_n) begin
			hcount <= '0;
			vcount <= '0;
		end else if (hcount == h_cnt_w'(h_total - 1)) begin
			hcount <= '0;
			if (vcount == v_cnt_w'(v_total - 1))
				vcount <= '0;
			else
				vcount <= vcount + 1'b1;
		end else begin
			hcount <= hcount + 1'b1;
		end
	end

	// fetch two pixels ahead, wrapping into the next line
	always_comb begin
		if (hcount >= h_cnt_w'(h_total - 2)) begin
			fetch_x = hcount + h_cnt_w'(2) - h_cnt_w'(h_total);
			fetch_y = (vcount == v_cnt_w'(v_total - 1)) ? '0 : vcount + 1'b1;
		end else begin
			fetch_x = hcount + h_cnt_w'(2);
			fetch_y = vcount;
		end
	end

	assign vid_fetch = (hcount[2:0] == 3'd6) && (fetch_x < h_active) && (fetch_y < v_active);
	assign vid_addr  = vram_aw'(fetch_y * bytes_per_line + (fetch_x >> 3));

	assign visible = (hcount < h_active) && (vcount < v_active);

	always_comb begin
		if (!overlay_en)
			band_colour = colour_mid;
		else if (vcount < band_top_rows)
			band_colour = colour_top;
		else if (vcount >= v_active - band_bottom_rows)
			band_colour = colour_bottom;
		else
			band_colour = colour_mid;
	end

	// byte arrives while hcount mod 8 is 7
	always_ff @(posedge clk_mist) begin
		if (hcount[2:0] == 3'd7)
			shifter <= vid_rdata;
		else
			shifter <= {shifter[6:0], 1'b0};
	end

	always_ff @(posedge clk_mist or negedge arst_n) begin
		if (!arst_n) begin
			pixel <= '0;
			de    <= 1'b0;
			hsync <= 1'b0;
			vsync <= 1'b0;
		end else begin
			de    <= visible;
			pixel <= (visible && shifter[7]) ? band_colour : '0; // msb first
			hsync <= (hcount >= h_sync_start) && (hcount < h_sync_end);
			vsync <= (vcount == v_sync_line);
		end
	end

endmodule

/* hdl/vram_arbiter.sv */
module vram_arbiter
	import arcade_video_pkg::*;
(
	input  logic               clk_mist,
	input  logic               arst_n,
	input  logic               cpu_strobe,
	input  vram_req_t          cpu_req,
	input  logic               vid_fetch,
	input  logic [vram_aw-1:0] vid_addr,
	input  logic [7:0]         ram_rdata,
	output logic               cpu_done,
	output logic [7:0]         cpu_rdata,
	output logic [7:0]         vid_rdata,
	output vram_req_t          ram_req
);

	vram_req_t pending_req;
	logic      pending;
	logic      cpu_issue;

	// video always wins, the CPU waits one slot at most
	assign cpu_issue = pending & ~vid_fetch;

	always_ff @(posedge clk_mist) begin
		if (cpu_strobe)
			pending_req <= cpu_req;
	end

	always_ff @(posedge clk_mist or negedge arst_n) begin
		if (!arst_n) begin
			pending  <= 1'b0;
			cpu_done <= 1'b0;
		end else begin
			cpu_done <= cpu_issue; // read data lands with done
			if (cpu_strobe)
				pending <= 1'b1;
			else if (cpu_issue)
				pending <= 1'b0;
		end
	end

	always_comb begin
		if (vid_fetch) begin
			ram_req = '{we: 1'b0, addr: vid_addr, wdata: 8'h00};
		end else begin
			ram_req    = pending_req;
			ram_req.we = pending_req.we & pending; // idle slots never write
		end
	end

	// one RAM read port feeds both peers, each knows its own slot
	assign cpu_rdata = ram_rdata;
	assign vid_rdata = ram_rdata;

endmodule

/* project.f */
hdl/arcade_ctrl_pkg.sv
hdl/arcade_video_pkg.sv
hdl/control_mapper.sv
hdl/vram_arbiter.sv
hdl/video_ram.sv
hdl/video_scanner.sv
hdl/arcade_io_top.sv
sim/tb_arcade_io.sv

/* sim/stim_input.txt */
# op: K code pressed | J joy0 joy1 rotate controls | W addr data | R addr data | F fill and scan
# all values hex, controls is the 9-bit cabinet word from coin down to bomb
K 76 1
K 05 1
K 3c 1
K 76 0
K 75 1
J 00 00 1 088
K 75 0
K 05 0
J 08 00 0 020
J 08 00 1 008
J 00 01 1 020
J 04 02 1 014
J 10 20 0 003
J 00 00 0 000
W 03 a5
R 03 a5
W 1f 3c
R 1f 3c
F
W 07 81
R 07 81

/* sim/tb_arcade_io.sv */
module tb_arcade_io
	import arcade_ctrl_pkg::*, arcade_video_pkg::*;
();

	localparam int   frame_clks   = h_total * v_total;
	localparam rgb_t colour_white = 3'b111;

	logic          clk_mist;
	logic          arst_n;
	logic          key_strobe;
	logic          key_pressed;
	logic [7:0]    key_code;
	logic [7:0]    joystick_0;
	logic [7:0]    joystick_1;
	logic          rotate;
	logic          overlay_en;
	logic          cpu_strobe;
	vram_req_t     cpu_req;
	cabinet_ctrl_t controls;
	logic          cpu_done;
	logic [7:0]    cpu_rdata;
	rgb_t          pixel;
	logic          de;
	logic          hsync;
	logic          vsync;

	cabinet_ctrl_t kb_model;            // keyboard button registers
	logic [7:0]    shadow [vram_depth]; // bitmap as the CPU wrote it
	int            ctrl_errs;
	int            cpu_errs;
	int            video_errs;
	int            file_errs;
	int            watch_clks;

	arcade_io_top i_arcade_io_top (.*);

	initial begin
		clk_mist = 1'b0;
		forever #2 clk_mist = ~clk_mist;
	end

	initial begin : watchdog
		wait (watch_clks > 0);
		repeat (watch_clks) @(posedge clk_mist);
		$display("timeout after %0d clocks, the run stopped making progress", watch_clks);
		report_counts();
		$display("Result: FAILED");
		$finish;
	end

	task automatic report_counts();
		$display("errors: controls %0d cpu %0d video %0d stimulus %0d total %0d",
			ctrl_errs, cpu_errs, video_errs, file_errs,
			ctrl_errs + cpu_errs + video_errs + file_errs);
	endtask

	task automatic step();
		@(posedge clk_mist);
		#1;
	endtask

	function automatic cabinet_ctrl_t key_update(input cabinet_ctrl_t kb,
			input logic [7:0] code, input logic pressed);
		cabinet_ctrl_t upd;
		upd = kb;
		case (code)
			key_coin:   upd.coin   = pressed;
			key_start1: upd.start1 = pressed;
			key_start2: upd.start2 = pressed;
			key_up:     upd.up     = pressed;
			key_down:   upd.down   = pressed;
			key_left:   upd.left   = pressed;
			key_right:  upd.right  = pressed;
			key_fire:   upd.fire   = pressed;
			key_bomb:   upd.bomb   = pressed;
			default:    ; // unknown code leaves the buttons alone
		endcase
		return upd;
	endfunction

	function automatic cabinet_ctrl_t expect_controls(input cabinet_ctrl_t kb,
			input logic [7:0] j0, input logic [7:0] j1, input logic rot);
		logic [7:0]    j;
		logic          u;
		logic          d;
		logic          l;
		logic          r;
		cabinet_ctrl_t e;
		j      = j0 | j1;
		u      = kb.up | j[joy_up];
		d      = kb.down | j[joy_down];
		l      = kb.left | j[joy_left];
		r      = kb.right | j[joy_right];
		e      = kb;
		e.fire = kb.fire | j[joy_fire];
		e.bomb = kb.bomb | j[joy_bomb];
		e.up    = rot ? r : u; // quarter turn when rotated
		e.down  = rot ? l : d;
		e.left  = rot ? u : l;
		e.right = rot ? d : r;
		return e;
	endfunction

	function automatic rgb_t expect_pixel(input logic lit, input logic ov, input int y);
		if (!lit)
			return '0;
		if (!ov)
			return colour_white;
		if (y < band_top_rows)
			return colour_top;
		if (y >= v_active - band_bottom_rows)
			return colour_bottom;
		return colour_mid;
	endfunction

	function automatic logic [7:0] fill_byte(input int a);
		return 8'(a * 37 + 8'h5c) ^ {a[2:0], a[4:0]};
	endfunction

	task automatic check_controls();
		cabinet_ctrl_t want;
		want = expect_controls(kb_model, joystick_0, joystick_1, rotate);
		@(negedge clk_mist);
		if (controls !== want) begin
			$display("FAIL t=%0t controls expected %h got %h", $time, want, controls);
			ctrl_errs++;
		end
		step();
	endtask

	task automatic cpu_access(input logic we, input logic [vram_aw-1:0] addr,
			input logic [7:0] wdata);
		bit got;
		got           = 1'b0;
		cpu_req.we    = we;
		cpu_req.addr  = addr;
		cpu_req.wdata = wdata;
		cpu_strobe    = 1'b1;
		step();
		cpu_strobe = 1'b0;
		for (int i = 0; i < 3 && !got; i++) begin
			@(negedge clk_mist);
			if (cpu_done) begin
				got = 1'b1;
				if (!we && cpu_rdata !== shadow[addr]) begin
					$display("FAIL t=%0t cpu_rdata at %0d expected %h got %h",
						$time, addr, shadow[addr], cpu_rdata);
					cpu_errs++;
				end
			end
		end
		if (!got) begin
			$display("cpu_done never came within 3 cycles of the strobe for address %0d", addr);
			cpu_errs++;
		end
		if (we)
			shadow[addr] = wdata;
		@(negedge clk_mist);
		if (got && cpu_done !== 1'b0) begin
			$display("FAIL t=%0t cpu_done expected 0 got %b", $time, cpu_done);
			cpu_errs++;
		end
		step();
	endtask

	task automatic wait_rise(input bit on_vsync, output bit seen);
		logic last;
		logic now;
		last = 1'b1; // skip a level that is already high
		seen = 1'b0;
		for (int n = 0; n < 2 * frame_clks && !seen; n++) begin
			@(negedge clk_mist);
			now  = on_vsync ? vsync : de;
			seen = now & ~last;
			last = now;
		end
		if (!seen) begin
			if (on_vsync)
				$display("no vsync pulse within two frames, the frame is missing");
			else
				$display("de never rose within two frames, the frame is missing");
			video_errs++;
		end
	endtask

	task automatic scan_frame(input logic ov);
		bit   seen;
		int   npix;
		int   hs_cnt;
		int   vs_cnt;
		int   line;
		int   pos;
		int   x;
		int   y;
		logic de_want;
		rgb_t want;
		npix       = 0;
		hs_cnt     = 0;
		vs_cnt     = 0;
		overlay_en = ov;
		wait_rise(1'b1, seen);
		if (seen)
			wait_rise(1'b0, seen); // lands on pixel 0,0
		for (int c = 0; c < frame_clks && seen; c++) begin
			if (c > 0)
				@(negedge clk_mist);
			line    = c / h_total;
			pos     = c % h_total;
			de_want = (line < v_active && pos < h_active);
			if (de !== de_want) begin
				$display("FAIL t=%0t de line %0d clock %0d expected %b got %b",
					$time, line, pos, de_want, de);
				video_errs++;
			end
			if (de && npix < h_active * v_active) begin
				x    = npix % h_active;
				y    = npix / h_active;
				want = expect_pixel(shadow[y * bytes_per_line + x / 8][7 - x % 8], ov, y);
				if (pixel !== want) begin
					$display("FAIL t=%0t pixel x %0d y %0d expected %b got %b",
						$time, x, y, want, pixel);
					video_errs++;
				end
			end
			npix   += de;
			hs_cnt += hsync;
			vs_cnt += vsync;
			if (pos == h_total - 1) begin
				if (hs_cnt != h_sync_end - h_sync_start) begin
					$display("FAIL t=%0t hsync clocks in line %0d expected %0d got %0d",
						$time, line, h_sync_end - h_sync_start, hs_cnt);
					video_errs++;
				end
				hs_cnt = 0;
			end
		end
		if (seen && npix != h_active * v_active) begin
			$display("FAIL t=%0t de pixel count expected %0d got %0d",
				$time, h_active * v_active, npix);
			video_errs++;
		end
		if (seen && vs_cnt != h_total) begin
			$display("FAIL t=%0t vsync clocks expected %0d got %0d", $time, h_total, vs_cnt);
			video_errs++;
		end
		step();
	endtask

	task automatic fill_and_scan();
		bit                 seen;
		logic [vram_aw-1:0] a;
		for (int i = 0; i < vram_depth; i++)
			cpu_access(1'b1, vram_aw'(i), fill_byte(i));
		// one write and a read back at each fetch phase of a visible line
		for (int p = 0; p < 8; p++) begin
			wait_rise(1'b0, seen);
			step();
			repeat (p) step();
			a = vram_aw'(p * 9 + 2);
			cpu_access(1'b1, a, ~shadow[a]);
			cpu_access(1'b0, a, 8'h00);
		end
		scan_frame(1'b0);
		scan_frame(1'b1);
	endtask

	initial begin : main_flow
		int               fd;
		int               n_lines;
		int               n_fill;
		int               code;
		logic [7:0]       op;
		logic [15:0]      a0;
		logic [15:0]      a1;
		logic [15:0]      a2;
		logic [15:0]      a3;
		logic [8*128-1:0] rest;
		cabinet_ctrl_t    want;
		arst_n      = 1'b0;
		key_strobe  = 1'b0;
		key_pressed = 1'b0;
		key_code    = 8'h00;
		joystick_0  = 8'h00;
		joystick_1  = 8'h00;
		rotate      = 1'b0;
		overlay_en  = 1'b0;
		cpu_strobe  = 1'b0;
		cpu_req     = '0;
		kb_model    = '0;
		n_lines     = 0;
		n_fill      = 0;
		fd = $fopen("sim/stim_input.txt", "r");
		if (fd == 0) begin
			$display("cannot open sim/stim_input.txt");
			file_errs++;
		end else begin
			while ($fscanf(fd, "%s", op) == 1) begin
				if (op != "#")
					n_lines++;
				if (op == "F")
					n_fill++;
				code = $fgets(rest, fd);
			end
			$fclose(fd);
			fd = $fopen("sim/stim_input.txt", "r");
		end
		watch_clks = 20 * (n_lines + 5) + n_fill * (8 * vram_depth + 8 * frame_clks);
		repeat (5) @(posedge clk_mist);
		#1;
		arst_n = 1'b1;
		step();
		while (fd != 0 && $fscanf(fd, "%s", op) == 1) begin
			case (op)
				"#": code = $fgets(rest, fd);
				"K": begin
					code        = $fscanf(fd, "%h %h", a0, a1);
					key_code    = a0[7:0];
					key_pressed = a1[0];
					key_strobe  = 1'b1;
					step();
					key_strobe = 1'b0;
					kb_model   = key_update(kb_model, a0[7:0], a1[0]);
					check_controls();
				end
				"J": begin
					code       = $fscanf(fd, "%h %h %h %h", a0, a1, a2, a3);
					joystick_0 = a0[7:0];
					joystick_1 = a1[7:0];
					rotate     = a2[0];
					want = expect_controls(kb_model, a0[7:0], a1[7:0], a2[0]);
					if (want !== a3[8:0]) begin
						$display("stimulus file gives controls %h where the rules give %h",
							a3[8:0], want);
						file_errs++;
					end
					check_controls();
				end
				"W": begin
					code = $fscanf(fd, "%h %h", a0, a1);
					cpu_access(1'b1, a0[vram_aw-1:0], a1[7:0]);
				end
				"R": begin
					code = $fscanf(fd, "%h %h", a0, a1);
					if (shadow[a0[vram_aw-1:0]] !== a1[7:0]) begin
						$display("stimulus file expects %h at %0d but the bitmap holds %h",
							a1[7:0], a0[vram_aw-1:0], shadow[a0[vram_aw-1:0]]);
						file_errs++;
					end
					cpu_access(1'b0, a0[vram_aw-1:0], 8'h00);
				end
				"F": fill_and_scan();
				default: begin
					$display("unknown stimulus line starting with %s", op);
					file_errs++;
					code = $fgets(rest, fd);
				end
			endcase
		end
		if (fd != 0)
			$fclose(fd);
		report_counts();
		if (ctrl_errs + cpu_errs + video_errs + file_errs == 0)
			$display("Result: PASSED");
		else
			$display("Result: FAILED");
		$finish;
	end

endmodule
